// ==== rtl/ddr_bridge_cfg.svh ====
/*
 * widths and address step shared by the line bridge
 */
`ifndef DDR_BRIDGE_CFG_SVH
`define DDR_BRIDGE_CFG_SVH

// ------------------------------
// cpu side
`define DDR_LINE_W      256  // one cache line
`define DDR_CPU_ADDR_W  30   // word address, 4 byte aligned

// ------------------------------
// controller user interface
`define DDR_BEAT_W      128  // app_wdf_data / app_rd_data
`define DDR_APP_ADDR_W  27
`define DDR_HALF_STRIDE 8    // addr step, low beat to high beat
`define DDR_APP_CMD_W   3

`endif

// ==== rtl/ddr_bridge_pkg.sv ====
/*
 * command encoding and the two views of the cpu word address
 */
`include "ddr_bridge_cfg.svh"

package ddr_bridge_pkg;

    // MIG app_cmd values, only these two are issued
    typedef enum logic [`DDR_APP_CMD_W-1:0] {
        APP_CMD_WRITE = 3'b000,
        APP_CMD_READ  = 3'b001
    } app_cmd_e;

    // flat view for repeat compare, field view for address forming
    typedef union packed {
        logic [`DDR_CPU_ADDR_W-1:0] flat;
        struct packed {
            logic [`DDR_CPU_ADDR_W-`DDR_APP_ADDR_W:0] unused_hi; // dropped, top of range
            logic [`DDR_APP_ADDR_W-5:0]               line_idx;  // 23 bits
            logic                                     half_sel;  // which 128b half
            logic [1:0]                               word_sel;  // word in half
        } fld;
    } cpu_addr_u;

endpackage

// ==== rtl/app_if.sv ====
/*
 * command issue channel, one engine to the port arbiter
 */
`timescale 1ns/100ps
`include "ddr_bridge_cfg.svh"

interface app_if import ddr_bridge_pkg::*;;

    app_cmd_e                  cmd;
    logic [`DDR_APP_ADDR_W-1:0] addr;
    logic                      req;   // held with cmd until gnt
    logic                      gnt;   // one command (+ beat) moves this cycle
    logic [`DDR_BEAT_W-1:0]    wdata;
    logic                      last;  // second command of the line

    modport engine (
        output cmd, addr, req, wdata, last,
        input  gnt
    );

    modport arbiter (
        input  cmd, addr, req, wdata, last,
        output gnt
    );

endinterface

// ==== rtl/cpu_req_front.sv ====
/*
 * cpu request front end: accept, repeat-read detect, dispatch to engines
 */
`timescale 1ns/100ps
`include "ddr_bridge_cfg.svh"

module cpu_req_front import ddr_bridge_pkg::*; (
    input  logic                   ui_clk,
    input  logic                   rst,
    input  logic                   ram_en,
    input  logic                   ram_write,
    input  cpu_addr_u              ram_addr,
    input  logic [`DDR_LINE_W-1:0] data_to_ram,
    input  logic                   calib_done,
    input  logic                   wr_done,
    input  logic                   rd_done,
    output logic                   ram_rdy,
    output logic                   wr_start,
    output logic                   rd_start,
    output cpu_addr_u              req_addr,
    output logic [`DDR_LINE_W-1:0] req_data,
    output logic                   hit_load
);

    localparam logic [2:0] ST_INIT = 3'd0; // waiting for calibration
    localparam logic [2:0] ST_IDLE = 3'd1;
    localparam logic [2:0] ST_HIT  = 3'd2; // answered from line buffer
    localparam logic [2:0] ST_WR   = 3'd3;
    localparam logic [2:0] ST_RD   = 3'd4;

    logic [2:0] state;
    logic       accept;
    logic       is_hit;
    logic       job_end;
    logic       last_valid;  // last_addr holds a finished op
    cpu_addr_u  last_addr;

    assign ram_rdy = (state == ST_IDLE);
    assign accept  = ram_en & ram_rdy;
    // same word as the last finished op, whatever it was
    assign is_hit  = last_valid & ~ram_write & (ram_addr.flat == last_addr.flat);
    assign job_end = ((state == ST_WR) & wr_done) | ((state == ST_RD) & rd_done);
    assign hit_load = (state == ST_WR) & wr_done; // refresh buffer with written line

    // ------------------------------
    // control fsm
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            state      <= ST_INIT;
            wr_start   <= 1'b0;
            rd_start   <= 1'b0;
            last_valid <= 1'b0;
        end else begin
            wr_start <= 1'b0; // single cycle pulses
            rd_start <= 1'b0;
            case (state)
                ST_INIT: if (calib_done) state <= ST_IDLE;
                ST_IDLE: begin
                    if (accept) begin
                        if (ram_write) begin
                            state    <= ST_WR;
                            wr_start <= 1'b1;
                        end else if (is_hit) begin
                            state <= ST_HIT;
                        end else begin
                            state    <= ST_RD;
                            rd_start <= 1'b1;
                        end
                    end
                end
                ST_HIT:  state <= ST_IDLE; // one cycle low
                ST_WR, ST_RD: begin
                    if (job_end) begin
                        state      <= ST_IDLE;
                        last_valid <= 1'b1;
                    end
                end
                default: state <= ST_INIT;
            endcase
        end
    end

    // ------------------------------
    // request and history payload
    always_ff @(posedge ui_clk) begin
        if (accept) begin
            req_addr <= ram_addr;
            req_data <= data_to_ram;
        end
        if (job_end) last_addr <= req_addr;
    end

endmodule

// ==== rtl/line_write_engine.sv ====
/*
 * line write engine: two write commands with their data beats
 */
`timescale 1ns/100ps
`include "ddr_bridge_cfg.svh"

module line_write_engine import ddr_bridge_pkg::*; (
    input  logic                   ui_clk,
    input  logic                   rst,
    input  logic                   wr_start,
    input  cpu_addr_u              req_addr,
    input  logic [`DDR_LINE_W-1:0] req_data,
    app_if.engine                  port_if,
    output logic                   wr_done
);

    logic                       busy;      // req held high
    logic                       beat;      // 0 low half, 1 high half
    logic [`DDR_APP_ADDR_W-1:0] base_addr;

    // line index * 16, top address bits dropped
    assign base_addr = {req_addr.fld.line_idx, 4'b0000};

    // ------------------------------
    // command side, stable until gnt
    assign port_if.req   = busy;
    assign port_if.cmd   = APP_CMD_WRITE;
    assign port_if.last  = beat;
    assign port_if.addr  = beat ? base_addr + `DDR_APP_ADDR_W'(`DDR_HALF_STRIDE)
                                : base_addr;
    assign port_if.wdata = beat ? req_data[`DDR_LINE_W-1:`DDR_BEAT_W]
                                : req_data[`DDR_BEAT_W-1:0];

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            busy    <= 1'b0;
            beat    <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            if (wr_start) begin
                busy <= 1'b1; // first req next cycle
                beat <= 1'b0;
            end else if (busy && port_if.gnt) begin
                if (!beat) begin
                    beat <= 1'b1; // straight on to the high half
                end else begin
                    busy    <= 1'b0;
                    beat    <= 1'b0;
                    wr_done <= 1'b1; // one cycle after second grant
                end
            end
        end
    end

endmodule

// ==== rtl/line_read_engine.sv ====
/*
 * line read engine: two read commands, beat assembly into the line buffer
 */
`timescale 1ns/100ps
`include "ddr_bridge_cfg.svh"

module line_read_engine import ddr_bridge_pkg::*; (
    input  logic                   ui_clk,
    input  logic                   rst,
    input  logic                   rd_start,
    input  cpu_addr_u              req_addr,
    input  logic                   hit_load,
    input  logic [`DDR_LINE_W-1:0] req_data,
    input  logic                   beat_valid,
    input  logic [`DDR_BEAT_W-1:0] beat_data,
    app_if.engine                  port_if,
    output logic                   rd_done,
    output logic [`DDR_LINE_W-1:0] line_buf
);

    logic                       issuing;   // commands still to send
    logic                       cmd_beat;  // which command is on the port
    logic                       rx_active; // beats still expected
    logic                       rx_beat;   // next returning half
    logic [`DDR_APP_ADDR_W-1:0] base_addr;

    assign base_addr = {req_addr.fld.line_idx, 4'b0000};

    assign port_if.req   = issuing;
    assign port_if.cmd   = APP_CMD_READ;
    assign port_if.last  = cmd_beat;
    assign port_if.addr  = cmd_beat ? base_addr + `DDR_APP_ADDR_W'(`DDR_HALF_STRIDE)
                                    : base_addr;
    assign port_if.wdata = '0; // no data on reads

    // ------------------------------
    // issue and receive counters, independent so both reads can be in flight
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            issuing   <= 1'b0;
            cmd_beat  <= 1'b0;
            rx_active <= 1'b0;
            rx_beat   <= 1'b0;
            rd_done   <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            if (rd_start) begin
                issuing   <= 1'b1;
                cmd_beat  <= 1'b0;
                rx_active <= 1'b1;
                rx_beat   <= 1'b0;
            end else begin
                if (issuing && port_if.gnt) begin
                    cmd_beat <= ~cmd_beat;
                    if (cmd_beat) issuing <= 1'b0; // both sent
                end
                if (rx_active && beat_valid) begin
                    rx_beat <= 1'b1;
                    if (rx_beat) begin
                        rx_active <= 1'b0;
                        rd_done   <= 1'b1; // a cycle after the second beat
                    end
                end
            end
        end
    end

    // line buffer, first beat low half, second high half
    always_ff @(posedge ui_clk) begin
        if (hit_load) begin
            line_buf <= req_data; // written line becomes the cached line
        end else if (rx_active && beat_valid) begin
            if (!rx_beat) line_buf[`DDR_BEAT_W-1:0] <= beat_data;
            else          line_buf[`DDR_LINE_W-1:`DDR_BEAT_W] <= beat_data;
        end
    end

endmodule

// ==== rtl/app_port_arbiter.sv ====
/*
 * arbiter for the single MIG app port: read priority, per-line lock,
 * calibration gating and read data steering
 */
`timescale 1ns/100ps
`include "ddr_bridge_cfg.svh"

module app_port_arbiter import ddr_bridge_pkg::*; (
    input  logic                       ui_clk,
    input  logic                       rst,
    input  logic                       app_rdy,
    input  logic                       app_wdf_rdy,
    input  logic                       init_calib_complete,
    input  logic [`DDR_BEAT_W-1:0]     app_rd_data,
    input  logic                       app_rd_data_valid,
    app_if.arbiter                     wr_port,
    app_if.arbiter                     rd_port,
    output logic                       app_en,
    output logic [`DDR_APP_CMD_W-1:0]  app_cmd,
    output logic [`DDR_APP_ADDR_W-1:0] app_addr,
    output logic [`DDR_BEAT_W-1:0]     app_wdf_data,
    output logic                       app_wdf_wren,
    output logic                       app_wdf_end,
    output logic                       calib_done,
    output logic                       beat_valid,
    output logic [`DDR_BEAT_W-1:0]     beat_data
);

    logic     calib_q;
    logic     lock_valid; // an engine owns the port
    logic     lock_rd;    // owner is the read engine
    logic     sel_rd;
    logic     sel_req;
    logic     sel_last;
    logic     grant;
    app_cmd_e sel_cmd;

    // ------------------------------
    // selection
    assign sel_rd   = lock_valid ? lock_rd : rd_port.req; // reads first when free
    assign sel_req  = sel_rd ? rd_port.req  : wr_port.req;
    assign sel_cmd  = sel_rd ? rd_port.cmd  : wr_port.cmd;
    assign sel_last = sel_rd ? rd_port.last : wr_port.last;

    // a write is only offered when its beat can go along
    assign app_en = sel_req & calib_q & ((sel_cmd != APP_CMD_WRITE) | app_wdf_rdy);
    assign grant  = app_en & app_rdy;

    assign wr_port.gnt = grant & ~sel_rd;
    assign rd_port.gnt = grant & sel_rd;

    assign app_cmd      = sel_cmd;
    assign app_addr     = sel_rd ? rd_port.addr  : wr_port.addr;
    assign app_wdf_data = sel_rd ? rd_port.wdata : wr_port.wdata;
    assign app_wdf_wren = grant & (sel_cmd == APP_CMD_WRITE); // beat with its command
    assign app_wdf_end  = app_wdf_wren; // single beat per command

    // read beats only ever belong to the read engine
    assign beat_valid = app_rd_data_valid;
    assign beat_data  = app_rd_data;
    assign calib_done = calib_q;

    // lock from first offer until the line's last command goes
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            calib_q    <= 1'b0;
            lock_valid <= 1'b0;
            lock_rd    <= 1'b0;
        end else begin
            calib_q <= init_calib_complete;
            if (grant && sel_last) begin
                lock_valid <= 1'b0;
            end else if (sel_req && calib_q) begin
                lock_valid <= 1'b1;
                lock_rd    <= sel_rd;
            end
        end
    end

endmodule

// ==== rtl/ddr_bridge_top.sv ====
/*
 * bridge top: cpu line port to MIG user interface
 */
`timescale 1ns/100ps
`include "ddr_bridge_cfg.svh"

module ddr_bridge_top import ddr_bridge_pkg::*; (
    input  logic                       ui_clk,
    input  logic                       rst,
    // cpu side
    input  logic                       ram_en,
    input  logic                       ram_write,
    input  logic [`DDR_CPU_ADDR_W-1:0] ram_addr,
    input  logic [`DDR_LINE_W-1:0]     data_to_ram,
    output logic                       ram_rdy,
    output logic [`DDR_LINE_W-1:0]     block_out,
    // controller app port
    output logic                       app_en,
    output logic [`DDR_APP_CMD_W-1:0]  app_cmd,
    output logic [`DDR_APP_ADDR_W-1:0] app_addr,
    output logic [`DDR_BEAT_W-1:0]     app_wdf_data,
    output logic                       app_wdf_wren,
    output logic                       app_wdf_end,
    input  logic                       app_rdy,
    input  logic                       app_wdf_rdy,
    input  logic [`DDR_BEAT_W-1:0]     app_rd_data,
    input  logic                       app_rd_data_valid,
    input  logic                       init_calib_complete
);

    logic                   calib_done;
    logic                   wr_start;
    logic                   rd_start;
    logic                   wr_done;
    logic                   rd_done;
    logic                   hit_load;
    logic                   beat_valid;
    logic [`DDR_BEAT_W-1:0] beat_data;
    logic [`DDR_LINE_W-1:0] req_data;
    cpu_addr_u              req_addr;

    app_if wr_if ();
    app_if rd_if ();

    cpu_req_front cpu_req_front_inst (
        .ui_clk      (ui_clk),
        .rst         (rst),
        .ram_en      (ram_en),
        .ram_write   (ram_write),
        .ram_addr    (ram_addr),
        .data_to_ram (data_to_ram),
        .calib_done  (calib_done),
        .wr_done     (wr_done),
        .rd_done     (rd_done),
        .ram_rdy     (ram_rdy),
        .wr_start    (wr_start),
        .rd_start    (rd_start),
        .req_addr    (req_addr),
        .req_data    (req_data),
        .hit_load    (hit_load)
    );

    line_write_engine line_write_engine_inst (
        .ui_clk   (ui_clk),
        .rst      (rst),
        .wr_start (wr_start),
        .req_addr (req_addr),
        .req_data (req_data),
        .port_if  (wr_if.engine),
        .wr_done  (wr_done)
    );

    line_read_engine line_read_engine_inst (
        .ui_clk     (ui_clk),
        .rst        (rst),
        .rd_start   (rd_start),
        .req_addr   (req_addr),
        .hit_load   (hit_load),
        .req_data   (req_data),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .port_if    (rd_if.engine),
        .rd_done    (rd_done),
        .line_buf   (block_out)
    );

    app_port_arbiter app_port_arbiter_inst (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .init_calib_complete (init_calib_complete),
        .app_rd_data         (app_rd_data),
        .app_rd_data_valid   (app_rd_data_valid),
        .wr_port             (wr_if.arbiter),
        .rd_port             (rd_if.arbiter),
        .app_en              (app_en),
        .app_cmd             (app_cmd),
        .app_addr            (app_addr),
        .app_wdf_data        (app_wdf_data),
        .app_wdf_wren        (app_wdf_wren),
        .app_wdf_end         (app_wdf_end),
        .calib_done          (calib_done),
        .beat_valid          (beat_valid),
        .beat_data           (beat_data)
    );

endmodule

// ==== test/mig_app_model.sv ====
/*
 * behavioural MIG user interface: beat memory, random ready stalls, read latency
 */
`timescale 1ns/100ps
`include "ddr_bridge_cfg.svh"

module mig_app_model import ddr_bridge_pkg::*; (
    input  logic                       ui_clk,
    input  logic                       rst,
    input  logic                       app_en,
    input  logic [`DDR_APP_CMD_W-1:0]  app_cmd,
    input  logic [`DDR_APP_ADDR_W-1:0] app_addr,
    input  logic [`DDR_BEAT_W-1:0]     app_wdf_data,
    input  logic                       app_wdf_wren,
    input  logic                       app_wdf_end,
    output logic                       app_rdy,
    output logic                       app_wdf_rdy,
    output logic [`DDR_BEAT_W-1:0]     app_rd_data,
    output logic                       app_rd_data_valid,
    output logic                       init_calib_complete
);

    localparam int CALIB_CYCLES = 12; // calibration time after reset

    logic [`DDR_BEAT_W-1:0] mem [logic [`DDR_APP_ADDR_W-1:0]];
    logic [`DDR_BEAT_W-1:0] rq_data [$]; // read beats in command order
    int                     rq_due [$];  // cycle each beat may return
    int                     cycle;
    int                     calib_cnt;
    int                     last_due;
    int                     delay;

    // contents of a beat never written, spread over the whole address
    function automatic logic [`DDR_BEAT_W-1:0] init_beat(input logic [`DDR_APP_ADDR_W-1:0] a);
        logic [31:0] w;
        w = {5'd0, a};
        return {w ^ 32'hc3a5_0000, ~w, w + 32'd7, w};
    endfunction

    initial begin
        app_rdy             = 1'b0;
        app_wdf_rdy         = 1'b0;
        app_rd_data         = '0;
        app_rd_data_valid   = 1'b0;
        init_calib_complete = 1'b0;
        cycle               = 0;
        calib_cnt           = 0;
        last_due            = 0;
        forever begin
            @(negedge ui_clk); // mid-cycle, same values the DUT takes at the next edge
            if (!rst) begin
                calib_cnt = 0;
                rq_data.delete();
                rq_due.delete();
            end else begin
                if (calib_cnt < CALIB_CYCLES) calib_cnt++;
                if (app_en && app_rdy) begin
                    if (app_cmd == APP_CMD_READ) begin
                        rq_data.push_back(mem.exists(app_addr) ? mem[app_addr]
                                                               : init_beat(app_addr));
                        delay    = int'($urandom_range(5, 1));
                        last_due = (cycle + delay > last_due) ? cycle + delay : last_due + 1;
                        rq_due.push_back(last_due); // never overtakes an older read
                    end else if (app_wdf_wren && app_wdf_end) begin
                        mem[app_addr] = app_wdf_data;
                    end
                end
            end
            // ------------------------------
            // outputs move 1 ns after the edge
            @(posedge ui_clk);
            #1;
            cycle++;
            init_calib_complete = (calib_cnt >= CALIB_CYCLES);
            app_rdy     = ($urandom_range(3, 0) != 0); // stalls about one cycle in four
            app_wdf_rdy = ($urandom_range(4, 0) != 0);
            if (rq_due.size() > 0 && rq_due[0] <= cycle) begin
                app_rd_data_valid = 1'b1;
                app_rd_data       = rq_data.pop_front();
                void'(rq_due.pop_front());
            end else begin
                app_rd_data_valid = 1'b0;
            end
        end
    end

endmodule

// ==== test/ddr_bridge_sva.sv ====
/*
 * bound checks on the MIG app port and the cpu handshake
 */
`timescale 1ns/100ps
`include "ddr_bridge_cfg.svh"

module ddr_bridge_sva import ddr_bridge_pkg::*; (
    input logic                       ui_clk,
    input logic                       rst,
    input logic                       ram_en,
    input logic                       ram_rdy,
    input logic                       app_en,
    input logic                       app_rdy,
    input logic [`DDR_APP_CMD_W-1:0]  app_cmd,
    input logic [`DDR_APP_ADDR_W-1:0] app_addr,
    input logic                       app_wdf_wren,
    input logic                       wr_start,
    input logic                       rd_start,
    input logic                       wr_done,
    input logic                       rd_done
);

    logic wr_active; // write engine started, done not yet seen
    logic rd_active; // same for the read engine

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            wr_active <= 1'b0;
            rd_active <= 1'b0;
        end else begin
            if (wr_start) wr_active <= 1'b1;
            else if (wr_done) wr_active <= 1'b0;
            if (rd_start) rd_active <= 1'b1;
            else if (rd_done) rd_active <= 1'b0;
        end
    end

    // offered command held until taken
    assert property (@(posedge ui_clk) disable iff (!rst)
        app_en && !app_rdy |=> $stable(app_cmd) && $stable(app_addr))
        else $error("app command changed while stalled");

    assert property (@(posedge ui_clk) disable iff (!rst)
        app_en && !app_rdy && app_cmd == APP_CMD_READ |=> app_en)
        else $error("read command withdrawn before app_rdy");

    // data beats only belong to a line write
    assert property (@(posedge ui_clk) disable iff (!rst)
        app_wdf_wren |-> wr_active && !rd_active)
        else $error("write beat outside a line write");

    // cpu side
    assert property (@(posedge ui_clk) disable iff (!rst)
        ram_en && ram_rdy |=> !ram_rdy)
        else $error("ram_rdy still high after an accepted request");

    assert property (@(posedge ui_clk) disable iff (!rst)
        wr_active || rd_active || wr_start || rd_start |-> !ram_rdy)
        else $error("ram_rdy high while a line job runs");

endmodule

// ==== test/ddr_bridge_tb.sv ====
/*
 * line bridge testbench: clock, reset, stimulus table, line scoreboard, report
 */
`timescale 1ns/100ps
`include "ddr_bridge_cfg.svh"

module ddr_bridge_tb;

    localparam int RDY_TIMEOUT = 400; // cycles per wait

    logic                       ui_clk;
    logic                       rst;
    logic                       ram_en;
    logic                       ram_write;
    logic [`DDR_CPU_ADDR_W-1:0] ram_addr;
    logic [`DDR_LINE_W-1:0]     data_to_ram;
    logic                       ram_rdy;
    logic [`DDR_LINE_W-1:0]     block_out;
    logic                       app_en;
    logic [`DDR_APP_CMD_W-1:0]  app_cmd;
    logic [`DDR_APP_ADDR_W-1:0] app_addr;
    logic [`DDR_BEAT_W-1:0]     app_wdf_data;
    logic                       app_wdf_wren;
    logic                       app_wdf_end;
    logic                       app_rdy;
    logic                       app_wdf_rdy;
    logic [`DDR_BEAT_W-1:0]     app_rd_data;
    logic                       app_rd_data_valid;
    logic                       init_calib_complete;

    // ------------------------------
    // stimulus table, one entry per cpu request
    string                      row_name [$];
    bit                         row_wr   [$];
    logic [`DDR_CPU_ADDR_W-1:0] row_addr [$];
    logic [`DDR_LINE_W-1:0]     row_data [$];
    bit                         row_hit  [$]; // expected one cycle low

    logic [`DDR_LINE_W-1:0] ref_mem [logic [22:0]]; // written lines by line index
    int                     check_count;
    int                     error_count;
    bit                     timed_out;

    ddr_bridge_top ddr_bridge_top_inst (.*);
    mig_app_model mig_app_model_inst (.*);
    bind ddr_bridge_top ddr_bridge_sva ddr_bridge_sva_inst (.*);

    initial begin
        ui_clk = 1'b0;
        forever #20 ui_clk = ~ui_clk;
    end

    task automatic check_val(input string name, input logic [`DDR_LINE_W-1:0] exp,
                             input logic [`DDR_LINE_W-1:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("error %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic add_row(input string name, input bit wr, input logic [29:0] addr,
                           input logic [`DDR_LINE_W-1:0] data, input bit hit);
        row_name.push_back(name);
        row_wr.push_back(wr);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_hit.push_back(hit);
    endtask

    // unwritten DDR content per app address
    function automatic logic [`DDR_BEAT_W-1:0] blank_beat(input logic [`DDR_APP_ADDR_W-1:0] a);
        logic [31:0] w;
        w = {5'd0, a};
        return {w ^ 32'hc3a5_0000, ~w, w + 32'd7, w};
    endfunction

    // line index is word address bits 25..3, beats at idx*16 and idx*16+8
    function automatic logic [`DDR_LINE_W-1:0] expect_line(input logic [29:0] a);
        logic [22:0] idx;
        idx = a[25:3];
        if (ref_mem.exists(idx)) return ref_mem[idx];
        return {blank_beat({idx, 4'h8}), blank_beat({idx, 4'h0})};
    endfunction

    // falling edges with ram_rdy low until it rises
    task automatic wait_rdy(input string what, output int low_cycles);
        bit seen;
        seen = 1'b0;
        low_cycles = 0;
        while (!seen && low_cycles < RDY_TIMEOUT) begin
            @(negedge ui_clk);
            if (ram_rdy) seen = 1'b1;
            else low_cycles++;
        end
        if (!seen) begin
            timed_out = 1'b1;
            error_count++;
            $display("timeout waiting for ram_rdy during %s", what);
        end
    endtask

    task automatic run_row(input int i);
        int low_cycles;
        wait_rdy({row_name[i], " start"}, low_cycles);
        if (timed_out) return;
        @(posedge ui_clk);
        #1;
        ram_en      = 1'b1;
        ram_write   = row_wr[i];
        ram_addr    = row_addr[i];
        data_to_ram = row_data[i];
        @(posedge ui_clk); // taken here
        #1;
        ram_en = 1'b0;
        wait_rdy(row_name[i], low_cycles);
        if (timed_out) return;
        check_val({row_name[i], " hit"}, `DDR_LINE_W'(row_hit[i]),
                  `DDR_LINE_W'(low_cycles == 1));
        if (row_wr[i]) ref_mem[row_addr[i][25:3]] = row_data[i];
        else check_val(row_name[i], expect_line(row_addr[i]), block_out);
    endtask

    task automatic build_table();
        logic [`DDR_LINE_W-1:0] d;
        add_row("wr_a",        1'b1, 30'h0000_0040, {{4{32'ha1a1_0001}}, {4{32'ha0a0_0000}}}, 1'b0);
        add_row("rd_b_blank",  1'b0, 30'h0000_1238, '0, 1'b0);
        add_row("rd_a",        1'b0, 30'h0000_0040, '0, 1'b0);
        add_row("rd_a_again",  1'b0, 30'h0000_0040, '0, 1'b1);
        add_row("wr_c",        1'b1, 30'h0012_3450, {{4{32'hc1c1_0011}}, {4{32'hc0c0_0010}}}, 1'b0);
        add_row("rd_c_hit",    1'b0, 30'h0012_3450, '0, 1'b1);
        add_row("rd_a_word5",  1'b0, 30'h0000_0045, '0, 1'b0); // same line, other word
        add_row("rd_a_word5b", 1'b0, 30'h0000_0045, '0, 1'b1);
        add_row("wr_a_new",    1'b1, 30'h0000_0040, {{4{32'hd3d3_0021}}, {4{32'hd2d2_0020}}}, 1'b0);
        add_row("rd_a_hit",    1'b0, 30'h0000_0040, '0, 1'b1);
        add_row("rd_a_alias",  1'b0, 30'h3c00_0040, '0, 1'b0); // top bits dropped
        add_row("wr_b",        1'b1, 30'h0000_1238, {{4{32'hb1b1_0031}}, {4{32'hb0b0_0030}}}, 1'b0);
        add_row("rd_c",        1'b0, 30'h0012_3450, '0, 1'b0);
        add_row("rd_b",        1'b0, 30'h0000_1238, '0, 1'b0);
        // random lines, all misses since no two neighbours share an address
        for (int k = 0; k < 8; k++) begin
            for (int j = 0; j < 8; j++) d[j*32 +: 32] = $urandom();
            add_row($sformatf("wr_rand%0d", k), 1'b1, {4'h0, 23'(k + 256), 3'd0}, d, 1'b0);
        end
        for (int k = 0; k < 8; k++) begin
            add_row($sformatf("rd_rand%0d", k), 1'b0, {4'h0, 23'(k + 256), 3'd0}, '0, 1'b0);
        end
    endtask

    // ------------------------------
    // main sequence
    initial begin
        int  cnt;
        bit  calib_seen;
        void'($urandom(60));
        rst         = 1'b0;
        ram_en      = 1'b0;
        ram_write   = 1'b0;
        ram_addr    = '0;
        data_to_ram = '0;
        check_count = 0;
        error_count = 0;
        timed_out   = 1'b0;
        build_table();
        repeat (3) @(posedge ui_clk);
        #1;
        check_val("reset ram_rdy", '0, `DDR_LINE_W'(ram_rdy));
        check_val("reset app_en", '0, `DDR_LINE_W'(app_en));
        check_val("reset wren", '0, `DDR_LINE_W'(app_wdf_wren));
        rst = 1'b1;
        cnt = 0;
        calib_seen = 1'b0;
        while (!ram_rdy && cnt < RDY_TIMEOUT) begin // no ready before calibration
            @(negedge ui_clk);
            if (ram_rdy) check_val("rdy after calib", `DDR_LINE_W'(1), `DDR_LINE_W'(calib_seen));
            calib_seen |= init_calib_complete;
            cnt++;
        end
        if (!ram_rdy) begin
            timed_out = 1'b1;
            error_count++;
            $display("timeout waiting for ram_rdy after calibration");
        end
        for (int i = 0; i < row_name.size() && !timed_out; i++) begin
            run_row(i);
        end
        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) $display("sim passed");
        else $display("sim failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/ddr_bridge_pkg.sv
rtl/app_if.sv
rtl/cpu_req_front.sv
rtl/line_write_engine.sv
rtl/line_read_engine.sv
rtl/app_port_arbiter.sv
rtl/ddr_bridge_top.sv
test/mig_app_model.sv
test/ddr_bridge_sva.sv
test/ddr_bridge_tb.sv

// ==== Makefile ====
# Verilator build and run of the DDR line bridge testbench

SRCS := $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vddr_bridge_tb: tb.f $(SRCS)
	verilator --binary --timing --assert -f tb.f --top-module ddr_bridge_tb

run: obj_dir/Vddr_bridge_tb
	./obj_dir/Vddr_bridge_tb | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
